//--- verilog/z8Core_settings.svh
`ifndef Z8CORE_SETTINGS_SVH
`define Z8CORE_SETTINGS_SVH

// Bus widths
`define ADDR_W 16
`define DATA_W 8

// First fetch address after reset
`define RESET_PC 16'h000C

// General registers 00..7F
`define REG_COUNT 128

// Special registers
`define REG_FLAGS 8'hFC
`define REG_RP 8'hFD

// Bit positions in the flags register
`define FLAG_C 7
`define FLAG_Z 6
`define FLAG_S 5
`define FLAG_V 4

`endif

//--- verilog/z8Pkg.sv
`include "z8Core_settings.svh"

package z8Pkg;

    // Execution states
    typedef enum logic [2:0] {
        fetchWait,
        decode,
        aluExec,
        djnzDec,
        djnzBranch
    } cpuState;

    // Two-operand operations, coded by the upper opcode nibble
    typedef enum logic [3:0] {
        opAdd = 4'h0,
        opAdc = 4'h1,
        opSub = 4'h2,
        opSbc = 4'h3,
        opOr  = 4'h4,
        opAnd = 4'h5,
        opTcm = 4'h6,
        opTm  = 4'h7,
        opCp  = 4'hA,
        opXor = 4'hB
    } aluOp;

    // Branch conditions, upper half is the inverse of the lower half
    typedef enum logic [3:0] {
        ccF   = 4'h0,
        ccLt  = 4'h1,
        ccLe  = 4'h2,
        ccUle = 4'h3,
        ccOv  = 4'h4,
        ccMi  = 4'h5,
        ccZ   = 4'h6,
        ccC   = 4'h7,
        ccT   = 4'h8,
        ccGe  = 4'h9,
        ccGt  = 4'hA,
        ccUgt = 4'hB,
        ccNov = 4'hC,
        ccPl  = 4'hD,
        ccNz  = 4'hE,
        ccNc  = 4'hF
    } condCode;

    typedef struct packed {
        logic [`DATA_W-1:0] opcode;
        logic [`DATA_W-1:0] second;
        logic [`DATA_W-1:0] third;
        logic [`ADDR_W-1:0] nextPc;
    } instrBytesT;

    typedef struct packed {
        logic               valid;
        logic [7:0]         addr;
        logic [`DATA_W-1:0] data;
    } regWriteT;

    typedef struct packed {
        logic [`DATA_W-1:0] value;
        logic [`DATA_W-1:0] flags;
        logic               writeBack;
    } aluResultT;

endpackage

//--- verilog/fetchUnit.sv
`timescale 1ns/1ps
`include "z8Core_settings.svh"

module fetchUnit
    import z8Pkg::*;
(
    input  logic        clk,
    input  logic        arstN,
    input  logic        fetchGo,
    input  logic        pcLoad,
    input  logic [15:0] pcTarget,
    input  logic [7:0]  memDataRead,
    output logic [15:0] memAddr,
    output logic        memStrobe,
    output instrBytesT  instr,
    output logic        instrValid
);
    logic [`ADDR_W-1:0] pc;
    // Strobe owed for a following byte, or the very first fetch
    logic               strobing;
    logic               capturing;
    logic [1:0]         byteCnt;
    logic [3:0]         lenNibble;
    logic [1:0]         instrLen;
    logic               lastByte;
    logic [7:0]         opcodeQ;
    logic [7:0]         secondQ;
    logic [7:0]         thirdQ;

    // First fetch waits for reset release
    assign memStrobe = fetchGo || (strobing && arstN);
    assign memAddr = pcLoad ? pcTarget : pc;

    // Opcode is still on the bus while byte 0 is captured
    assign lenNibble = (byteCnt == 2'd0) ? memDataRead[3:0] : opcodeQ[3:0];

    always_comb begin
        if (lenNibble[3:1] == 3'b111) begin
            instrLen = 2'd1;
        end else if (lenNibble[3:2] == 2'b01 || lenNibble == 4'hD) begin
            instrLen = 2'd3;
        end else begin
            instrLen = 2'd2;
        end
    end

    assign lastByte = (byteCnt == instrLen - 2'd1);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= `RESET_PC;
            strobing <= 1'b1;
            capturing <= 1'b0;
            byteCnt <= 2'd0;
            instrValid <= 1'b0;
        end else begin
            instrValid <= 1'b0;
            strobing <= 1'b0;
            capturing <= memStrobe;
            if (memStrobe) begin
                pc <= memAddr + 1'b1;
            end
            if (capturing) begin
                if (lastByte) begin
                    instrValid <= 1'b1;
                    byteCnt <= 2'd0;
                end else begin
                    strobing <= 1'b1;
                    byteCnt <= byteCnt + 2'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capturing) begin
            case (byteCnt)
                2'd0: opcodeQ <= memDataRead;
                2'd1: secondQ <= memDataRead;
                default: thirdQ <= memDataRead;
            endcase
        end
    end

    // pc already points past the last strobed byte
    assign instr = '{opcode: opcodeQ, second: secondQ, third: thirdQ, nextPc: pc};

    // Execution must not restart fetch during the hand-over cycle
    assert property (@(posedge clk) disable iff (!arstN) instrValid |-> !$rose(memStrobe));

endmodule

//--- verilog/registerFile.sv
`timescale 1ns/1ps
`include "z8Core_settings.svh"

module registerFile
    import z8Pkg::*;
(
    input  logic       clk,
    input  logic       arstN,
    input  logic [7:0] readAddrA,
    input  logic [7:0] readAddrB,
    output logic [7:0] readDataA,
    output logic [7:0] readDataB,
    input  regWriteT   wb,
    input  logic [7:0] aluFlags,
    input  logic       flagsLoad,
    input  logic       srpLoad,
    input  logic [3:0] srpValue,
    input  logic [1:0] carryCtl,
    output logic [7:0] flags
);
    localparam int IdxW = $clog2(`REG_COUNT);

    logic [`DATA_W-1:0] regs [`REG_COUNT];
    logic [3:0]         rp;
    logic [7:0]         wbAddr;

    // Ex addresses reach working register x of the current bank
    function automatic logic [7:0] mapAddr(input logic [7:0] addr);
        return (addr[7:4] == 4'hE) ? {rp, addr[3:0]} : addr;
    endfunction

    function automatic logic [7:0] readReg(input logic [7:0] addr);
        logic [7:0] mapped;
        mapped = mapAddr(addr);
        if (mapped < `REG_COUNT) begin
            return regs[mapped[IdxW-1:0]];
        end
        if (mapped == `REG_FLAGS) begin
            return flags;
        end
        if (mapped == `REG_RP) begin
            return {rp, 4'h0};
        end
        // Unimplemented control registers
        return 8'h00;
    endfunction

    always_comb begin
        readDataA = readReg(readAddrA);
        readDataB = readReg(readAddrB);
        wbAddr = mapAddr(wb.addr);
    end

    always_ff @(posedge clk) begin
        if (wb.valid && wbAddr < `REG_COUNT) begin
            regs[wbAddr[IdxW-1:0]] <= wb.data;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            flags <= 8'h00;
            rp <= 4'h0;
        end else begin
            if (flagsLoad) begin
                flags <= aluFlags;
            end
            if (carryCtl[1]) begin
                flags[`FLAG_C] <= carryCtl[0];
            end
            if (srpLoad) begin
                rp <= srpValue;
            end
            // Explicit register write beats the ALU flag update
            if (wb.valid && wbAddr == `REG_FLAGS) begin
                flags <= wb.data;
            end
            if (wb.valid && wbAddr == `REG_RP) begin
                rp <= wb.data[7:4];
            end
        end
    end

    assert property (@(posedge clk) disable iff (!arstN) !(flagsLoad && carryCtl[1]));

endmodule

//--- verilog/alu.sv
`timescale 1ns/1ps
`include "z8Core_settings.svh"

module alu
    import z8Pkg::*;
(
    input  aluOp       op,
    input  logic [7:0] a,
    input  logic [7:0] b,
    input  logic [7:0] flagsIn,
    output aluResultT  result,
    input  condCode    cond,
    output logic       condTrue
);
    logic       carryIn;
    logic [8:0] wide;
    logic       isArith;
    logic       isSub;
    logic [7:0] value;
    logic [7:0] flagsOut;
    logic       condBase;

    assign carryIn = flagsIn[`FLAG_C];

    always_comb begin
        wide = {1'b0, a};
        isArith = 1'b1;
        isSub = 1'b0;
        case (op)
            opAdd: wide = a + b;
            opAdc: wide = a + b + carryIn;
            opSub, opCp: begin
                wide = a - b;
                isSub = 1'b1;
            end
            opSbc: begin
                wide = a - b - carryIn;
                isSub = 1'b1;
            end
            opOr: begin
                wide = {1'b0, a | b};
                isArith = 1'b0;
            end
            opAnd, opTm: begin
                wide = {1'b0, a & b};
                isArith = 1'b0;
            end
            opTcm: begin
                wide = {1'b0, ~a & b};
                isArith = 1'b0;
            end
            opXor: begin
                wide = {1'b0, a ^ b};
                isArith = 1'b0;
            end
            default: isArith = 1'b0;
        endcase

        value = wide[7:0];
        flagsOut = flagsIn;
        flagsOut[`FLAG_Z] = (value == 8'h00);
        flagsOut[`FLAG_S] = value[7];
        flagsOut[`FLAG_V] = 1'b0;
        if (isArith) begin
            // Bit 8 is the carry out, or the borrow for subtraction
            flagsOut[`FLAG_C] = wide[8];
            if (isSub) begin
                flagsOut[`FLAG_V] = (a[7] != b[7]) && (value[7] != a[7]);
            end else begin
                flagsOut[`FLAG_V] = (a[7] == b[7]) && (value[7] != a[7]);
            end
        end
    end

    assign result = '{
        value: value,
        flags: flagsOut,
        writeBack: !(op inside {opTcm, opTm, opCp})
    };

    always_comb begin
        case (condCode'({1'b0, cond[2:0]}))
            ccF:   condBase = 1'b0;
            ccLt:  condBase = flagsIn[`FLAG_S] ^ flagsIn[`FLAG_V];
            ccLe:  condBase = (flagsIn[`FLAG_S] ^ flagsIn[`FLAG_V]) | flagsIn[`FLAG_Z];
            ccUle: condBase = flagsIn[`FLAG_C] | flagsIn[`FLAG_Z];
            ccOv:  condBase = flagsIn[`FLAG_V];
            ccMi:  condBase = flagsIn[`FLAG_S];
            ccZ:   condBase = flagsIn[`FLAG_Z];
            ccC:   condBase = flagsIn[`FLAG_C];
            default: condBase = 1'b0;
        endcase
    end

    // Upper eight codes invert the lower eight
    assign condTrue = condBase ^ cond[3];

endmodule

//--- verilog/execUnit.sv
`timescale 1ns/1ps
`include "z8Core_settings.svh"

module execUnit
    import z8Pkg::*;
(
    input  logic        clk,
    input  logic        arstN,
    input  instrBytesT  instr,
    input  logic        instrValid,
    output logic        fetchGo,
    output logic        pcLoad,
    output logic [15:0] pcTarget,
    output logic [7:0]  readAddrA,
    output logic [7:0]  readAddrB,
    input  logic [7:0]  readDataA,
    input  logic [7:0]  readDataB,
    input  logic [7:0]  flags,
    output aluOp        op,
    output logic [7:0]  a,
    output logic [7:0]  b,
    input  aluResultT   result,
    output condCode     cond,
    input  logic        condTrue,
    output regWriteT    wb,
    output logic        flagsLoad,
    output logic        srpLoad,
    output logic [3:0]  srpValue,
    output logic [1:0]  carryCtl
);
    cpuState            state;
    cpuState            stateNext;
    logic [3:0]         hi;
    logic [3:0]         lo;
    logic               isAluInstr;
    logic [7:0]         dstAddr;
    logic [7:0]         workReg;
    logic [`ADDR_W-1:0] relTarget;

    assign hi = instr.opcode[7:4];
    assign lo = instr.opcode[3:0];

    // Upper nibbles 0-7, A and B are two-operand operations in the x2 and x6 forms
    assign isAluInstr = (!hi[3] || hi[3:1] == 3'b101) && (lo == 4'h2 || lo == 4'h6);
    assign dstAddr = (lo == 4'h6) ? instr.second : {4'hE, instr.second[7:4]};
    assign workReg = {4'hE, hi};
    assign relTarget = instr.nextPc + {{8{instr.second[7]}}, instr.second};

    always_comb begin
        case (lo)
            4'h2, 4'h6: readAddrA = dstAddr;
            4'h8: readAddrA = instr.second;
            default: readAddrA = workReg;
        endcase
    end
    assign readAddrB = {4'hE, instr.second[3:0]};

    assign op = aluOp'(hi);
    assign a = readDataA;
    assign b = (lo == 4'h2) ? readDataB : instr.third;
    assign cond = condCode'(hi);
    assign srpValue = instr.second[7:4];

    always_comb begin
        stateNext = state;
        fetchGo = 1'b0;
        pcLoad = 1'b0;
        pcTarget = relTarget;
        wb = '0;
        flagsLoad = 1'b0;
        srpLoad = 1'b0;
        carryCtl = 2'b00;
        case (state)
            fetchWait: begin
                if (instrValid) begin
                    stateNext = decode;
                end
            end
            decode: begin
                if (isAluInstr) begin
                    stateNext = aluExec;
                end else if (lo == 4'hA) begin
                    stateNext = djnzDec;
                end else begin
                    stateNext = fetchWait;
                    fetchGo = 1'b1;
                    case (lo)
                        4'h6: begin
                            if (hi == 4'hE) begin
                                wb = '{valid: 1'b1, addr: instr.second, data: instr.third};
                            end
                        end
                        4'h8: wb = '{valid: 1'b1, addr: workReg, data: readDataA};
                        4'hC: wb = '{valid: 1'b1, addr: workReg, data: instr.second};
                        4'hB: pcLoad = condTrue;
                        4'hD: begin
                            pcLoad = condTrue;
                            pcTarget = {instr.second, instr.third};
                        end
                        4'h1: srpLoad = (hi == 4'h3);
                        4'hF: begin
                            // Carry control as {update, new carry}
                            case (hi)
                                4'hC: carryCtl = 2'b10;
                                4'hD: carryCtl = 2'b11;
                                4'hE: carryCtl = {1'b1, ~flags[`FLAG_C]};
                                default: carryCtl = 2'b00;
                            endcase
                        end
                        default: ;
                    endcase
                end
            end
            aluExec: begin
                stateNext = fetchWait;
                fetchGo = 1'b1;
                flagsLoad = 1'b1;
                wb = '{valid: result.writeBack, addr: dstAddr, data: result.value};
            end
            djnzDec: begin
                // Decrement bypasses the ALU so the flags stay as they are
                stateNext = djnzBranch;
                wb = '{valid: 1'b1, addr: workReg, data: readDataA - 8'd1};
            end
            djnzBranch: begin
                // Register already holds the decremented count
                stateNext = fetchWait;
                fetchGo = 1'b1;
                pcLoad = (readDataA != 8'h00);
            end
            default: stateNext = fetchWait;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= fetchWait;
        end else begin
            state <= stateNext;
        end
    end

    // A new instruction only arrives while execution is idle
    assert property (@(posedge clk) disable iff (!arstN) instrValid |-> (state == fetchWait));

endmodule

//--- verilog/z8Core.sv
`timescale 1ns/1ps

module z8Core
    import z8Pkg::*;
(
    input  logic        clk,
    input  logic        arstN,
    output logic [15:0] memAddr,
    output logic        memStrobe,
    input  logic [7:0]  memDataRead,
    output regWriteT    wb
);
    instrBytesT  instr;
    logic        instrValid;
    logic        fetchGo;
    logic        pcLoad;
    logic [15:0] pcTarget;
    logic [7:0]  readAddrA;
    logic [7:0]  readAddrB;
    logic [7:0]  readDataA;
    logic [7:0]  readDataB;
    logic [7:0]  flags;
    logic        flagsLoad;
    logic        srpLoad;
    logic [3:0]  srpValue;
    logic [1:0]  carryCtl;
    aluOp        op;
    logic [7:0]  a;
    logic [7:0]  b;
    aluResultT   result;
    condCode     cond;
    logic        condTrue;

    fetchUnit fetchUnit_inst (
        .clk(clk),
        .arstN(arstN),
        .fetchGo(fetchGo),
        .pcLoad(pcLoad),
        .pcTarget(pcTarget),
        .memDataRead(memDataRead),
        .memAddr(memAddr),
        .memStrobe(memStrobe),
        .instr(instr),
        .instrValid(instrValid)
    );

    registerFile registerFile_inst (
        .clk(clk),
        .arstN(arstN),
        .readAddrA(readAddrA),
        .readAddrB(readAddrB),
        .readDataA(readDataA),
        .readDataB(readDataB),
        .wb(wb),
        .aluFlags(result.flags),
        .flagsLoad(flagsLoad),
        .srpLoad(srpLoad),
        .srpValue(srpValue),
        .carryCtl(carryCtl),
        .flags(flags)
    );

    alu alu_inst (
        .op(op),
        .a(a),
        .b(b),
        .flagsIn(flags),
        .result(result),
        .cond(cond),
        .condTrue(condTrue)
    );

    execUnit execUnit_inst (
        .clk(clk),
        .arstN(arstN),
        .instr(instr),
        .instrValid(instrValid),
        .fetchGo(fetchGo),
        .pcLoad(pcLoad),
        .pcTarget(pcTarget),
        .readAddrA(readAddrA),
        .readAddrB(readAddrB),
        .readDataA(readDataA),
        .readDataB(readDataB),
        .flags(flags),
        .op(op),
        .a(a),
        .b(b),
        .result(result),
        .cond(cond),
        .condTrue(condTrue),
        .wb(wb),
        .flagsLoad(flagsLoad),
        .srpLoad(srpLoad),
        .srpValue(srpValue),
        .carryCtl(carryCtl)
    );

endmodule

//--- verif/z8CoreChecker.sv
`timescale 1ns/1ps
`include "z8Core_settings.svh"

module z8CoreChecker
    import z8Pkg::*;
(
    input  logic        clk,
    input  logic        arstN,
    input  logic [15:0] memAddr,
    input  logic        memStrobe,
    input  regWriteT    wb,
    output logic        done,
    output int          errorCount,
    output int          checkedCount
);
    // Copy of the program, loaded by the testbench before reset release
    logic [7:0]  progMem [65536];
    logic [7:0]  regs [`REG_COUNT];
    logic [7:0]  flagsQ;
    logic [3:0]  rpQ;
    logic [15:0] expPc;
    logic [15:0] instrPc;
    int          byteIdx;
    int          curLen;
    logic        pendValid;
    logic [7:0]  pendAddr;
    logic [7:0]  pendData;

    initial begin
        flagsQ = 8'h00;
        rpQ = 4'h0;
        expPc = `RESET_PC;
        instrPc = `RESET_PC;
        byteIdx = 0;
        curLen = 1;
        pendValid = 1'b0;
        pendAddr = 8'h00;
        pendData = 8'h00;
        done = 1'b0;
        errorCount = 0;
        checkedCount = 0;
    end

    function automatic int lenOf(input logic [7:0] opcode);
        if (opcode[3:1] == 3'b111) begin
            return 1;
        end
        if (opcode[3:2] == 2'b01 || opcode[3:0] == 4'hD) begin
            return 3;
        end
        return 2;
    endfunction

    function automatic logic [7:0] mapped(input logic [7:0] addr);
        return (addr[7:4] == 4'hE) ? {rpQ, addr[3:0]} : addr;
    endfunction

    function automatic logic [7:0] readReg(input logic [7:0] addr);
        logic [7:0] m;
        m = mapped(addr);
        if (m < `REG_COUNT) begin
            return regs[m[6:0]];
        end
        if (m == `REG_FLAGS) begin
            return flagsQ;
        end
        if (m == `REG_RP) begin
            return {rpQ, 4'h0};
        end
        return 8'h00;
    endfunction

    function automatic void storeReg(input logic [7:0] addr, input logic [7:0] data);
        logic [7:0] m;
        m = mapped(addr);
        if (m < `REG_COUNT) begin
            regs[m[6:0]] = data;
        end else if (m == `REG_FLAGS) begin
            flagsQ = data;
        end else if (m == `REG_RP) begin
            rpQ = data[7:4];
        end
    endfunction

    function automatic logic condHolds(input logic [3:0] c);
        logic s;
        logic v;
        logic z;
        logic cy;
        logic base;
        s = flagsQ[`FLAG_S];
        v = flagsQ[`FLAG_V];
        z = flagsQ[`FLAG_Z];
        cy = flagsQ[`FLAG_C];
        case (c[2:0])
            3'd0: base = 1'b0;
            3'd1: base = s ^ v;
            3'd2: base = (s ^ v) | z;
            3'd3: base = cy | z;
            3'd4: base = v;
            3'd5: base = s;
            3'd6: base = z;
            default: base = cy;
        endcase
        return base ^ c[3];
    endfunction

    // Updates the model flags, returns the value and whether it is stored
    function automatic void aluStep(input logic [3:0] opNib, input logic [7:0] a,
            input logic [7:0] b, output logic [7:0] value, output logic keep);
        logic [8:0] w;
        logic       arith;
        logic       sub;
        logic       cin;
        cin = flagsQ[`FLAG_C];
        arith = 1'b1;
        sub = 1'b0;
        case (opNib)
            4'h0: w = {1'b0, a} + {1'b0, b};
            4'h1: w = {1'b0, a} + {1'b0, b} + cin;
            4'h2, 4'hA: begin
                w = {1'b0, a} - {1'b0, b};
                sub = 1'b1;
            end
            4'h3: begin
                w = {1'b0, a} - {1'b0, b} - cin;
                sub = 1'b1;
            end
            4'h4: begin
                w = {1'b0, a | b};
                arith = 1'b0;
            end
            4'h5, 4'h7: begin
                w = {1'b0, a & b};
                arith = 1'b0;
            end
            4'h6: begin
                w = {1'b0, ~a & b};
                arith = 1'b0;
            end
            default: begin
                w = {1'b0, a ^ b};
                arith = 1'b0;
            end
        endcase
        value = w[7:0];
        flagsQ[`FLAG_Z] = (value == 8'h00);
        flagsQ[`FLAG_S] = value[7];
        flagsQ[`FLAG_V] = 1'b0;
        if (arith) begin
            flagsQ[`FLAG_C] = w[8];
            if (sub) begin
                flagsQ[`FLAG_V] = (a[7] != b[7]) && (value[7] != a[7]);
            end else begin
                flagsQ[`FLAG_V] = (a[7] == b[7]) && (value[7] != a[7]);
            end
        end
        keep = !(opNib inside {4'h6, 4'h7, 4'hA});
    endfunction

    function automatic void execInstr(input logic [15:0] pc, output logic [15:0] nextPc,
            output logic wValid, output logic [7:0] wAddr, output logic [7:0] wData);
        logic [7:0]  opcode;
        logic [7:0]  s;
        logic [7:0]  t;
        logic [3:0]  hi;
        logic [3:0]  lo;
        logic [15:0] seqPc;
        logic [15:0] relPc;
        logic [7:0]  dst;
        logic [7:0]  value;
        logic        keep;
        opcode = progMem[pc];
        s = progMem[pc + 16'd1];
        t = progMem[pc + 16'd2];
        hi = opcode[7:4];
        lo = opcode[3:0];
        seqPc = pc + 16'(lenOf(opcode));
        relPc = seqPc + {{8{s[7]}}, s};
        nextPc = seqPc;
        wValid = 1'b0;
        wAddr = 8'h00;
        wData = 8'h00;
        case (lo)
            4'h2, 4'h6: begin
                if (lo == 4'h6 && hi == 4'hE) begin
                    wValid = 1'b1;
                    wAddr = s;
                    wData = t;
                end else if (hi < 4'h8 || hi == 4'hA || hi == 4'hB) begin
                    dst = (lo == 4'h6) ? s : {4'hE, s[7:4]};
                    aluStep(hi, readReg(dst), (lo == 4'h2) ? readReg({4'hE, s[3:0]}) : t,
                        value, keep);
                    wValid = keep;
                    wAddr = dst;
                    wData = value;
                end
            end
            4'h8: begin
                wValid = 1'b1;
                wAddr = {4'hE, hi};
                wData = readReg(s);
            end
            4'hC: begin
                wValid = 1'b1;
                wAddr = {4'hE, hi};
                wData = s;
            end
            4'hB: nextPc = condHolds(hi) ? relPc : seqPc;
            4'hD: nextPc = condHolds(hi) ? {s, t} : seqPc;
            4'hA: begin
                wAddr = {4'hE, hi};
                wData = readReg(wAddr) - 8'd1;
                storeReg(wAddr, wData);
                wValid = 1'b1;
                if (readReg(wAddr) != 8'h00) begin
                    nextPc = relPc;
                end
            end
            4'h1: begin
                if (hi == 4'h3) begin
                    rpQ = s[7:4];
                end
            end
            4'hF: begin
                if (hi == 4'hC) begin
                    flagsQ[`FLAG_C] = 1'b0;
                end else if (hi == 4'hD) begin
                    flagsQ[`FLAG_C] = 1'b1;
                end else if (hi == 4'hE) begin
                    flagsQ[`FLAG_C] = ~flagsQ[`FLAG_C];
                end
            end
            default: ;
        endcase
        if (wValid && lo != 4'hA) begin
            storeReg(wAddr, wData);
        end
    endfunction

    task automatic reportError(input string msg);
        $display("error at %0t: %s", $time, msg);
        errorCount++;
    endtask

    always @(posedge clk) begin
        logic [15:0] nxt;
        logic        pv;
        logic [7:0]  pa;
        logic [7:0]  pd;
        if (!arstN) begin
            if (wb.valid === 1'b1) begin
                reportError("write-back pulse while reset is active");
            end
            if (memStrobe === 1'b1) begin
                reportError("memory strobe while reset is active");
            end
        end else begin
            // Write first, since it can share a cycle with the next fetch
            if (wb.valid === 1'b1) begin
                if (!pendValid) begin
                    reportError($sformatf("unexpected write addr %h data %h, none expected",
                        wb.addr, wb.data));
                end else if (wb.addr !== pendAddr || wb.data !== pendData) begin
                    reportError($sformatf("write addr %h data %h, expected addr %h data %h",
                        wb.addr, wb.data, pendAddr, pendData));
                end
                pendValid = 1'b0;
            end
            if (memStrobe === 1'b1) begin
                if (byteIdx == 0) begin
                    if (pendValid) begin
                        reportError($sformatf("missing write addr %h data %h before %h",
                            pendAddr, pendData, memAddr));
                    end
                    pendValid = 1'b0;
                    instrPc = expPc;
                    curLen = lenOf(progMem[instrPc]);
                end
                if (memAddr !== instrPc + 16'(byteIdx)) begin
                    reportError($sformatf("fetch addr %h, expected %h",
                        memAddr, instrPc + 16'(byteIdx)));
                end
                byteIdx++;
                if (byteIdx == curLen) begin
                    byteIdx = 0;
                    execInstr(instrPc, nxt, pv, pa, pd);
                    pendValid = pv;
                    pendAddr = pa;
                    pendData = pd;
                    checkedCount++;
                    if (nxt == instrPc) begin
                        done = 1'b1;
                    end
                    expPc = nxt;
                end
            end
        end
    end

endmodule

//--- verif/z8CoreTb.sv
`timescale 1ns/1ps
`include "z8Core_settings.svh"

module z8CoreTb
    import z8Pkg::*;
();
    logic        clk;
    logic        arstN;
    logic [15:0] memAddr;
    logic        memStrobe;
    logic [7:0]  memDataRead;
    regWriteT    wb;
    logic        done;
    int          errorCount;
    int          checkedCount;

    logic [7:0]  progMem [65536];
    logic [15:0] emitPc;
    int          instrCount;
    int          seed;
    int          cycleCount;
    int          cycleLimit;

    z8Core z8Core_inst (
        .clk(clk),
        .arstN(arstN),
        .memAddr(memAddr),
        .memStrobe(memStrobe),
        .memDataRead(memDataRead),
        .wb(wb)
    );

    z8CoreChecker z8CoreChecker_inst (
        .clk(clk),
        .arstN(arstN),
        .memAddr(memAddr),
        .memStrobe(memStrobe),
        .wb(wb),
        .done(done),
        .errorCount(errorCount),
        .checkedCount(checkedCount)
    );

    always #4 clk = ~clk;

    // Synchronous program memory, one cycle after the strobe
    always @(posedge clk) begin
        if (memStrobe) begin
            memDataRead <= progMem[memAddr];
        end
    end

    function automatic int randBelow(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fffffff) % n;
    endfunction

    task automatic place(input logic [7:0] b);
        progMem[emitPc] = b;
        emitPc++;
    endtask

    task automatic emitTwo(input logic [7:0] b0, input logic [7:0] b1);
        place(b0);
        place(b1);
        instrCount++;
    endtask

    task automatic emitThree(input logic [7:0] b0, input logic [7:0] b1, input logic [7:0] b2);
        place(b0);
        place(b1);
        place(b2);
        instrCount++;
    endtask

    task automatic emitOne(input logic [7:0] b0);
        place(b0);
        instrCount++;
    endtask

    function automatic logic [3:0] aluNibble(input int i);
        if (i < 8) begin
            return 4'(i);
        end
        return (i == 8) ? 4'hA : 4'hB;
    endfunction

    // Registers 00..3F, working registers, or the flags
    function automatic logic [7:0] randDst();
        int sel;
        sel = randBelow(8);
        if (sel < 5) begin
            return 8'(randBelow(64));
        end
        if (sel < 7) begin
            return {4'hE, 4'(randBelow(16))};
        end
        return `REG_FLAGS;
    endfunction

    task automatic buildDirected();
        logic [7:0]  pats [4];
        logic [15:0] tgt;
        pats = '{8'h00, 8'hF0, 8'h20, 8'h90};
        // Fill banks 0..3 so no read sees an unwritten register
        for (int b = 0; b < 4; b++) begin
            emitTwo(8'h31, {4'(b), 4'h0});
            for (int r = 0; r < 16; r++) begin
                emitTwo({4'(r), 4'hC}, 8'((b * 16 + r) * 37 + 11));
            end
        end
        emitTwo(8'h31, 8'h00);
        emitThree(8'hE6, 8'h20, 8'h5A);
        emitTwo(8'h18, 8'h20);
        emitTwo(8'h3C, 8'h81);
        for (int i = 0; i < 10; i++) begin
            emitTwo({aluNibble(i), 4'h2}, 8'h13);
            emitThree({aluNibble(i), 4'h6}, 8'h2A, 8'(8'hC5 + i * 29));
        end
        // Carry control seen by adc
        emitOne(8'hDF);
        emitTwo(8'h12, 8'h13);
        emitOne(8'hCF);
        emitTwo(8'h12, 8'h13);
        emitOne(8'hEF);
        emitTwo(8'h12, 8'h13);
        // Bank switch reaches register 21 through r1
        emitTwo(8'h31, 8'h20);
        emitTwo(8'h1C, 8'h99);
        emitTwo(8'h28, 8'h21);
        emitTwo(8'h31, 8'h00);
        // Every condition, taken and not taken, for jr and jp
        for (int p = 0; p < 4; p++) begin
            emitThree(8'hE6, `REG_FLAGS, pats[p]);
            for (int c = 0; c < 16; c++) begin
                emitTwo({4'(c), 4'hB}, 8'h02);
                emitTwo(8'h0C, 8'hAA);
                tgt = emitPc + 16'd5;
                emitThree({4'(c), 4'hD}, tgt[15:8], tgt[7:0]);
                emitTwo(8'h0C, 8'h55);
            end
        end
        // Loop of five
        emitTwo(8'h5C, 8'h05);
        emitTwo(8'h5A, 8'hFE);
    endtask

    task automatic buildRandom(input int count);
        int          kind;
        int          k;
        logic [15:0] tgt;
        for (int n = 0; n < count; n++) begin
            kind = randBelow(10);
            k = randBelow(3);
            case (kind)
                0: emitTwo({4'(randBelow(16)), 4'hC}, 8'(randBelow(256)));
                1: emitThree(8'hE6, randDst(), 8'(randBelow(256)));
                2: emitTwo({4'(randBelow(16)), 4'h8}, randDst());
                3: emitTwo({aluNibble(randBelow(10)), 4'h2}, 8'(randBelow(256)));
                4: emitThree({aluNibble(randBelow(10)), 4'h6}, randDst(), 8'(randBelow(256)));
                5: emitTwo({4'(randBelow(16)), 4'hB}, 8'(2 * k));
                6: begin
                    tgt = emitPc + 16'(3 + 2 * k);
                    emitThree({4'(randBelow(16)), 4'hD}, tgt[15:8], tgt[7:0]);
                end
                7: emitTwo({4'(randBelow(16)), 4'hA}, 8'(2 * k));
                8: emitTwo(8'h31, {4'(randBelow(4)), 4'h0});
                default: emitOne(8'hCF + 8'(randBelow(4)) * 8'h10);
            endcase
            // Forward targets skip k fillers of two bytes
            if (kind >= 5 && kind <= 7) begin
                for (int f = 0; f < k; f++) begin
                    emitTwo({4'(randBelow(16)), 4'hC}, 8'(randBelow(256)));
                end
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        arstN = 1'b0;
        memDataRead = 8'h00;
        seed = 75697;
        instrCount = 0;
        cycleCount = 0;
        emitPc = `RESET_PC;
        for (int i = 0; i < 65536; i++) begin
            progMem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5A;
        end
        buildDirected();
        buildRandom(300);
        // Final jump to itself
        emitTwo(8'h8B, 8'hFE);
        for (int i = 0; i < 65536; i++) begin
            z8CoreChecker_inst.progMem[i] = progMem[i];
        end
        cycleLimit = (instrCount + 10) * 9 + 100;

        repeat (3) @(posedge clk);
        arstN <= 1'b1;
        while (!done && cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        repeat (4) @(posedge clk);
        if (!done) begin
            $display("timeout: the program did not reach its final jump within %0d cycles",
                cycleLimit);
        end
        $display("errors: %0d, instructions checked: %0d", errorCount, checkedCount);
        if (errorCount == 0 && done) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- z8Core.f
+incdir+verilog
verilog/z8Pkg.sv
verilog/fetchUnit.sv
verilog/registerFile.sv
verilog/alu.sv
verilog/execUnit.sv
verilog/z8Core.sv
verif/z8CoreChecker.sv
verif/z8CoreTb.sv
